// ==== link_defs.svh ====
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

//////////////////////////////////////////////////
// link dimensions
//////////////////////////////////////////////////

// width of the PRBS shift register, also the checker seek length
`define LINK_PRBS_W 32

// number of channel taps, main cursor plus post-cursors
`define LINK_TAPS 4

//////////////////////////////////////////////////
// status counters
//////////////////////////////////////////////////

// error and bit counters saturate at all ones
`define LINK_CNT_W 16

`endif

// ==== link_cfg_pkg.sv ====
`default_nettype none

`include "link_defs.svh"

package link_cfg_pkg;

    // emu_clk cycles per emulated clock level, zero acts as one
    typedef logic [3:0] half_period_t;

    // signed channel tap weight
    typedef logic signed [11:0] tap_coef_t;

    // index into the coefficient table
    typedef logic [$clog2(`LINK_TAPS)-1:0] tap_addr_t;

    // lfsr state, feedback equation mask or seed
    typedef logic [`LINK_PRBS_W-1:0] prbs_word_t;

endpackage

`default_nettype wire

// ==== link_sig_pkg.sv ====
`default_nettype none

`include "link_defs.svh"

package link_sig_pkg;

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    // signed channel output, wide enough for all taps at full scale
    typedef logic signed [15:0] chan_sample_t;

    //////////////////////////////////////////////////
    // receiver status
    //////////////////////////////////////////////////

    // saturating error or bit counter
    typedef logic [`LINK_CNT_W-1:0] link_cnt_t;

    // checker fsm
    typedef enum logic {
        CHK_SEEK,
        CHK_LOCKED
    } chk_state_t;

endpackage

`default_nettype wire

// ==== tx_clk_osc.sv ====
`default_nettype none

module tx_clk_osc
    import link_cfg_pkg::*;
(
    input  wire logic         emu_clk,
    input  wire logic         emu_rst,
    input  wire half_period_t half_lo_i,
    input  wire half_period_t half_hi_i,
    output logic              tx_clk_o,
    output logic              tx_edge_o
);

    // cycles left in the current level, minus one
    half_period_t cnt;

    // reload value for a level of the given length
    function automatic half_period_t level_load(input half_period_t half);
        if (half == '0) begin
            return '0;
        end
        return half - half_period_t'(1);
    endfunction

    //////////////////////////////////////////////////
    // level timer
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            tx_clk_o  <= 1'b0;
            tx_edge_o <= 1'b0;
            cnt       <= level_load(half_lo_i);
        end else if (cnt == '0) begin
            // level ends here, sample the length of the next one
            tx_clk_o  <= ~tx_clk_o;
            tx_edge_o <= ~tx_clk_o;
            if (tx_clk_o) begin
                cnt <= level_load(half_lo_i);
            end else begin
                cnt <= level_load(half_hi_i);
            end
        end else begin
            tx_edge_o <= 1'b0;
            cnt       <= cnt - half_period_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== prbs_gen.sv ====
`default_nettype none

`include "link_defs.svh"

module prbs_gen
    import link_cfg_pkg::*;
(
    input  wire logic       emu_clk,
    input  wire logic       emu_rst,
    input  wire logic       cke_i,
    input  wire logic       clr_i,
    input  wire prbs_word_t seed_i,
    input  wire prbs_word_t eqn_i,
    input  wire logic       inj_err_i,
    output logic            tx_bit_o
);

    prbs_word_t state;
    logic       next_bit;

    // feedback is the parity of the tapped state bits
    assign next_bit = ^(state & eqn_i);

    //////////////////////////////////////////////////
    // fibonacci lfsr
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst || clr_i) begin
            state <= seed_i;
        end else if (cke_i) begin
            state <= {state[`LINK_PRBS_W-2:0], next_bit};
        end
    end

    // injected error flips the output only, state stays on sequence
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            tx_bit_o <= 1'b0;
        end else if (cke_i) begin
            tx_bit_o <= next_bit ^ inj_err_i;
        end
    end

endmodule

`default_nettype wire

// ==== chan_fir.sv ====
`default_nettype none

`include "link_defs.svh"

module chan_fir
    import link_cfg_pkg::*;
    import link_sig_pkg::*;
(
    input  wire logic      emu_clk,
    input  wire logic      emu_rst,
    input  wire logic      sym_stb_i,
    input  wire logic      tx_bit_i,
    input  wire logic      we_i,
    input  wire tap_addr_t waddr_i,
    input  wire tap_coef_t wdata_i,
    output chan_sample_t   sample_o,
    output logic           sample_valid_o
);

    // tap weights, index 0 is the main cursor
    tap_coef_t coef [`LINK_TAPS];

    // past symbols, bit 0 is the most recent one
    logic [`LINK_TAPS-2:0] hist;

    // window seen on the strobe, current symbol at bit 0
    logic [`LINK_TAPS-1:0] window;

    chan_sample_t sum;

    assign window = {hist, tx_bit_i};

    //////////////////////////////////////////////////
    // coefficient write decode
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int k = 0; k < `LINK_TAPS; k++) begin
                coef[k] <= '0;
            end
        end else if (we_i) begin
            for (int k = 0; k < `LINK_TAPS; k++) begin
                if (waddr_i == tap_addr_t'(k)) begin
                    coef[k] <= wdata_i;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // convolution
    //////////////////////////////////////////////////

    // nrz symbol is +1 for a one and -1 for a zero
    always_comb begin
        chan_sample_t term;
        sum = '0;
        for (int k = 0; k < `LINK_TAPS; k++) begin
            term = chan_sample_t'(coef[k]);
            if (window[k]) begin
                sum = sum + term;
            end else begin
                sum = sum - term;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            hist           <= '0;
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= sym_stb_i;
            if (sym_stb_i) begin
                hist <= window[`LINK_TAPS-2:0];
            end
        end
    end

    // output sample, qualified by sample_valid_o
    always_ff @(posedge emu_clk) begin
        if (sym_stb_i) begin
            sample_o <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== rx_ber_checker.sv ====
`default_nettype none

`include "link_defs.svh"

module rx_ber_checker
    import link_cfg_pkg::*;
    import link_sig_pkg::*;
(
    input  wire logic         emu_clk,
    input  wire logic         emu_rst,
    input  wire logic         clr_i,
    input  wire prbs_word_t   eqn_i,
    input  wire chan_sample_t sample_i,
    input  wire logic         sample_valid_i,
    output logic              locked_o,
    output link_cnt_t         err_cnt_o,
    output link_cnt_t         bit_cnt_o
);

    localparam int SEEK_W = $clog2(`LINK_PRBS_W);

    chk_state_t        state;
    prbs_word_t        lfsr;
    logic [SEEK_W-1:0] seek_cnt;
    logic              dec_bit;
    logic              pred_bit;

    //////////////////////////////////////////////////
    // slicer and predictor
    //////////////////////////////////////////////////

    assign dec_bit  = (sample_i > chan_sample_t'(0));
    assign pred_bit = ^(lfsr & eqn_i);
    assign locked_o = (state == CHK_LOCKED);

    // seek loads received bits, lock runs on predicted bits only
    always_ff @(posedge emu_clk) begin
        if (sample_valid_i) begin
            if (state == CHK_SEEK) begin
                lfsr <= {lfsr[`LINK_PRBS_W-2:0], dec_bit};
            end else begin
                lfsr <= {lfsr[`LINK_PRBS_W-2:0], pred_bit};
            end
        end
    end

    //////////////////////////////////////////////////
    // checker fsm and counters
    //////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst || clr_i) begin
            state     <= CHK_SEEK;
            seek_cnt  <= '0;
            err_cnt_o <= '0;
            bit_cnt_o <= '0;
        end else if (sample_valid_i) begin
            case (state)
                CHK_SEEK: begin
                    // lfsr fully loaded after PRBS_W bits
                    seek_cnt <= seek_cnt + 1'b1;
                    if (seek_cnt == SEEK_W'(`LINK_PRBS_W - 1)) begin
                        state <= CHK_LOCKED;
                    end
                end
                CHK_LOCKED: begin
                    if (bit_cnt_o != '1) begin
                        bit_cnt_o <= bit_cnt_o + 1'b1;
                    end
                    if ((pred_bit != dec_bit) && (err_cnt_o != '1)) begin
                        err_cnt_o <= err_cnt_o + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== emu_link_top.sv ====
`default_nettype none

module emu_link_top
    import link_cfg_pkg::*;
    import link_sig_pkg::*;
(
    input  wire logic         emu_clk,
    input  wire logic         emu_rst,
    input  wire logic         clr_i,
    input  wire half_period_t half_lo_i,
    input  wire half_period_t half_hi_i,
    input  wire prbs_word_t   seed_i,
    input  wire prbs_word_t   eqn_i,
    input  wire logic         inj_err_i,
    input  wire logic         chan_we_i,
    input  wire tap_addr_t    chan_waddr_i,
    input  wire tap_coef_t    chan_wdata_i,
    output logic              tx_clk_o,
    output logic              tx_edge_o,
    output logic              locked_o,
    output link_cnt_t         err_cnt_o,
    output link_cnt_t         bit_cnt_o
);

    logic         tx_bit;
    logic         sym_stb;
    chan_sample_t sample;
    logic         sample_valid;

    //////////////////////////////////////////////////
    // tx clock and source
    //////////////////////////////////////////////////

    tx_clk_osc tx_clk_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .half_lo_i (half_lo_i),
        .half_hi_i (half_hi_i),
        .tx_clk_o  (tx_clk_o),
        .tx_edge_o (tx_edge_o)
    );

    prbs_gen prbs_gen_i (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .cke_i     (tx_edge_o),
        .clr_i     (clr_i),
        .seed_i    (seed_i),
        .eqn_i     (eqn_i),
        .inj_err_i (inj_err_i),
        .tx_bit_o  (tx_bit)
    );

    // tx_bit is valid one cycle after the edge
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            sym_stb <= 1'b0;
        end else begin
            sym_stb <= tx_edge_o;
        end
    end

    //////////////////////////////////////////////////
    // channel and receiver
    //////////////////////////////////////////////////

    chan_fir chan_i (
        .emu_clk        (emu_clk),
        .emu_rst        (emu_rst),
        .sym_stb_i      (sym_stb),
        .tx_bit_i       (tx_bit),
        .we_i           (chan_we_i),
        .waddr_i        (chan_waddr_i),
        .wdata_i        (chan_wdata_i),
        .sample_o       (sample),
        .sample_valid_o (sample_valid)
    );

    rx_ber_checker rx_chk_i (
        .emu_clk        (emu_clk),
        .emu_rst        (emu_rst),
        .clr_i          (clr_i),
        .eqn_i          (eqn_i),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .locked_o       (locked_o),
        .err_cnt_o      (err_cnt_o),
        .bit_cnt_o      (bit_cnt_o)
    );

endmodule

`default_nettype wire

// ==== link_asserts.sv ====
`default_nettype none

module link_asserts (
    input wire logic emu_clk,
    input wire logic emu_rst,
    input wire logic tx_edge_i,
    input wire logic sym_stb_i,
    input wire logic sample_valid_i,
    input wire logic locked_i
);

    // assertion failures seen so far
    int fail_count = 0;

    // tx edge is a single-cycle pulse
    edge_single: assert property (@(posedge emu_clk) disable iff (emu_rst)
        tx_edge_i |=> !tx_edge_i)
        else begin
            $error("tx edge high on two consecutive cycles");
            fail_count++;
        end

    // channel output follows the symbol strobe by one cycle
    valid_after_stb: assert property (@(posedge emu_clk) disable iff (emu_rst)
        sample_valid_i |-> $past(sym_stb_i))
        else begin
            $error("sample valid without a symbol strobe one cycle earlier");
            fail_count++;
        end

    unlocked_after_rst: assert property (@(posedge emu_clk)
        emu_rst |=> !locked_i)
        else begin
            $error("checker locked right after reset");
            fail_count++;
        end

endmodule

bind emu_link_top link_asserts asserts_i (
    .emu_clk        (emu_clk),
    .emu_rst        (emu_rst),
    .tx_edge_i      (tx_edge_o),
    .sym_stb_i      (sym_stb),
    .sample_valid_i (sample_valid),
    .locked_i       (locked_o)
);

`default_nettype wire

// ==== link_checker.sv ====
`default_nettype none

module link_checker
    import link_sig_pkg::*;
(
    input wire logic      emu_clk,
    input wire logic      emu_rst,
    input wire logic      tx_clk_i,
    input wire logic      tx_edge_i,
    input wire logic      locked_i,
    input wire link_cnt_t err_cnt_i,
    input wire link_cnt_t bit_cnt_i
);

    int pass_count  = 0;
    int fail_count  = 0;
    int since_edge  = 0;
    int edge_period = 0;
    int high_run    = 0;
    int high_len    = 0;
    bit test_bad    = 1'b0;

    // spacing of the two latest tx edges in emu_clk cycles
    always @(posedge emu_clk) begin
        if (emu_rst) begin
            since_edge  <= 0;
            edge_period <= 0;
        end else if (tx_edge_i) begin
            edge_period <= since_edge + 1;
            since_edge  <= 0;
        end else begin
            since_edge <= since_edge + 1;
        end
    end

    // length of the latest completed high level of the tx clock
    always @(posedge emu_clk) begin
        if (emu_rst) begin
            high_run <= 0;
            high_len <= 0;
        end else if (tx_clk_i) begin
            high_run <= high_run + 1;
        end else if (high_run != 0) begin
            high_len <= high_run;
            high_run <= 0;
        end
    end

    task automatic compare(input string name, input string what, input int exp, input int act);
        if (exp != act) begin
            $display("FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic expect_counts(input string name, input int exp_err, input int exp_bits);
        compare(name, "locked", 1, int'(locked_i));
        compare(name, "error count", exp_err, int'(err_cnt_i));
        compare(name, "bit count", exp_bits, int'(bit_cnt_i));
    endtask

    task automatic expect_cleared(input string name);
        compare(name, "locked after clear", 0, int'(locked_i));
        compare(name, "error count after clear", 0, int'(err_cnt_i));
        compare(name, "bit count after clear", 0, int'(bit_cnt_i));
    endtask

    task automatic expect_period(input string name, input int cycles);
        compare(name, "symbol period", cycles, edge_period);
    endtask

    task automatic expect_high_time(input string name, input int cycles);
        compare(name, "tx clock high time", cycles, high_len);
    endtask

    task automatic end_test(input string name);
        if (test_bad) begin
            fail_count++;
            $display("test %s: failed", name);
        end else begin
            pass_count++;
            $display("test %s: ok", name);
        end
        test_bad = 1'b0;
    endtask

endmodule

`default_nettype wire

// ==== tb_emu_link.sv ====
`default_nettype none

`include "link_defs.svh"

module tb_emu_link
    import link_cfg_pkg::*;
    import link_sig_pkg::*;
();

    localparam int NROWS    = 6;
    localparam int MAX_BITS = 256;
    // edge to counter update: prbs, channel and checker registers
    localparam int LATENCY  = 3;
    localparam prbs_word_t SEED = 32'hACE1_0F35;
    // x^7 + x^6
    localparam prbs_word_t EQN  = 32'h0000_0060;

    //////////////////////////////////////////////////
    // test table, one column per row field
    //////////////////////////////////////////////////

    // exp_tab of -1 takes the count from the reference model
    string names    [NROWS] = '{"clean", "inject", "isi", "inverted", "asym_clk", "mid_clear"};
    int    lo_tab   [NROWS] = '{2, 2, 2, 2, 3, 2};
    int    hi_tab   [NROWS] = '{2, 2, 3, 2, 5, 2};
    int    coef_tab [NROWS][`LINK_TAPS] = '{'{400, 0, 0, 0}, '{400, 0, 0, 0},
        '{400, 120, -80, 60}, '{-400, 0, 0, 0}, '{400, 0, 0, 0}, '{400, 0, 0, 0}};
    int    bits_tab [NROWS] = '{100, 120, 150, 80, 64, 90};
    int    inj_tab  [NROWS] = '{0, 5, 4, 0, 2, 3};
    int    exp_tab  [NROWS] = '{0, 5, 4, -1, 2, 3};
    int    mid_tab  [NROWS] = '{0, 0, 0, 0, 0, 1};

    logic         emu_clk = 1'b0;
    logic         emu_rst;
    logic         clr_i;
    half_period_t half_lo_i;
    half_period_t half_hi_i;
    prbs_word_t   seed_i;
    prbs_word_t   eqn_i;
    logic         inj_err_i;
    logic         chan_we_i;
    tap_addr_t    chan_waddr_i;
    tap_coef_t    chan_wdata_i;
    logic         tx_clk_o;
    logic         tx_edge_o;
    logic         locked_o;
    link_cnt_t    err_cnt_o;
    link_cnt_t    bit_cnt_o;

    // inj_at[i] flips the i-th symbol after a clear
    bit inj_at [MAX_BITS+1];
    int cycle_cnt      = 0;
    int timeout_cycles = 0;

    emu_link_top dut (.*);

    link_checker mon (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .tx_clk_i  (tx_clk_o),
        .tx_edge_i (tx_edge_o),
        .locked_i  (locked_o),
        .err_cnt_i (err_cnt_o),
        .bit_cnt_i (bit_cnt_o)
    );

    always #20 emu_clk = ~emu_clk;

    always @(posedge emu_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge emu_clk);
        #2;
    endtask

    task automatic write_coefs(input int r);
        for (int k = 0; k < `LINK_TAPS; k++) begin
            chan_we_i    = 1'b1;
            chan_waddr_i = tap_addr_t'(k);
            chan_wdata_i = tap_coef_t'(coef_tab[r][k]);
            next_cycle();
        end
        chan_we_i = 1'b0;
    endtask

    // clear two cycles after an edge, no old symbol can reach the checker
    task automatic clear_link();
        while (!tx_edge_o) begin
            next_cycle();
        end
        next_cycle();
        next_cycle();
        clr_i = 1'b1;
        next_cycle();
        clr_i = 1'b0;
    endtask

    // distinct random symbols past the seek window
    task automatic pick_errors(input int n, input int bits);
        int idx;
        foreach (inj_at[i]) begin
            inj_at[i] = 1'b0;
        end
        repeat (n) begin
            idx = 0;
            while (idx == 0 || inj_at[idx]) begin
                idx = `LINK_PRBS_W + 1 + int'($urandom % 32'(bits - `LINK_PRBS_W));
            end
            inj_at[idx] = 1'b1;
        end
    endtask

    task automatic send_bits(input int bits);
        int sent;
        sent = 0;
        while (sent < bits) begin
            inj_err_i = 1'b0;
            if (tx_edge_o) begin
                sent++;
                inj_err_i = inj_at[sent];
            end
            next_cycle();
        end
        inj_err_i = 1'b0;
        repeat (LATENCY - 1) begin
            next_cycle();
        end
    endtask

    // source lfsr from the seed, receiver seeks 32 decisions then free-runs
    function automatic int model_errors(input int bits, input bit invert);
        prbs_word_t tx_state;
        prbs_word_t rx_state;
        logic       b;
        logic       d;
        logic       p;
        int         errs;
        tx_state = SEED;
        rx_state = '0;
        errs     = 0;
        for (int i = 1; i <= bits; i++) begin
            b = ^(tx_state & EQN);
            tx_state = {tx_state[`LINK_PRBS_W-2:0], b};
            d = b ^ inj_at[i] ^ invert;
            p = ^(rx_state & EQN);
            if (i <= `LINK_PRBS_W) begin
                rx_state = {rx_state[`LINK_PRBS_W-2:0], d};
            end else begin
                rx_state = {rx_state[`LINK_PRBS_W-2:0], p};
                errs += int'(p != d);
            end
        end
        return errs;
    endfunction

    task automatic run_row(input int r);
        int exp_err;
        half_lo_i = half_period_t'(lo_tab[r]);
        half_hi_i = half_period_t'(hi_tab[r]);
        write_coefs(r);
        pick_errors(inj_tab[r], bits_tab[r]);
        exp_err = (exp_tab[r] < 0) ? model_errors(bits_tab[r], coef_tab[r][0] < 0) : exp_tab[r];
        clear_link();
        send_bits(bits_tab[r]);
        if (mid_tab[r] != 0) begin
            mon.expect_counts(names[r], exp_err, bits_tab[r] - `LINK_PRBS_W);
            clear_link();
            mon.expect_cleared(names[r]);
            pick_errors(0, bits_tab[r]);
            exp_err = 0;
            send_bits(bits_tab[r]);
        end
        mon.expect_counts(names[r], exp_err, bits_tab[r] - `LINK_PRBS_W);
        mon.expect_period(names[r], lo_tab[r] + hi_tab[r]);
        mon.expect_high_time(names[r], hi_tab[r]);
        mon.end_test(names[r]);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h278b));
        timeout_cycles = 200;
        for (int r = 0; r < NROWS; r++) begin
            timeout_cycles += (mid_tab[r] + 1) * (bits_tab[r] + 8) * (lo_tab[r] + hi_tab[r]);
        end
        emu_rst      = 1'b1;
        clr_i        = 1'b0;
        half_lo_i    = half_period_t'(lo_tab[0]);
        half_hi_i    = half_period_t'(hi_tab[0]);
        seed_i       = SEED;
        eqn_i        = EQN;
        inj_err_i    = 1'b0;
        chan_we_i    = 1'b0;
        chan_waddr_i = '0;
        chan_wdata_i = '0;
        repeat (4) begin
            @(posedge emu_clk);
        end
        #2;
        emu_rst = 1'b0;
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 NROWS, mon.pass_count, mon.fail_count, dut.asserts_i.fail_count);
        if (mon.fail_count == 0 && mon.pass_count == NROWS && dut.asserts_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
link_cfg_pkg.sv
link_sig_pkg.sv
tx_clk_osc.sv
prbs_gen.sv
chan_fir.sv
rx_ber_checker.sv
emu_link_top.sv
link_asserts.sv
link_checker.sv
tb_emu_link.sv

// ==== Makefile ====
# Verilator simulation of the emulated serial link

VERILATOR ?= verilator
TOP       ?= tb_emu_link
FILELIST  ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
